/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_LW,
    OP_SW,
    OP_BEQ,
    OP_BNE,
    OP_JAL
  } op_e;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic            valid;
    op_e             op;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    reg_addr_t       rd;
  } de_op_t;

  typedef struct packed {
    logic            we;
    reg_addr_t       rd;
    logic [XLEN-1:0] data;
  } rf_wr_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

/* common/mem_port_intf.sv */
`timescale 1ns/1ns
`default_nettype none

interface mem_port_intf
  import cpu_pkg::*;
();

  logic            req;
  logic            we;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;
  logic            gnt;
  logic            rvalid;
  logic [XLEN-1:0] rdata;

  modport master(output req, we, addr, wdata, input gnt, rvalid, rdata);

  modport arbiter(input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

/* core/ifetch.sv */
`timescale 1ns/1ns
`default_nettype none

module ifetch
  import cpu_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  mem_port_intf.master    imem,
  input  redirect_t       redirect_i,
  input  logic            pop_i,
  output logic            inst_valid_o,
  output logic [XLEN-1:0] inst_o,
  output logic [XLEN-1:0] inst_pc_o
);

  logic            active_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] resp_pc_q;
  logic            pend_q;
  logic            drop_q;
  logic [1:0]      count_q;
  logic            rd_ptr_q;
  logic            wr_ptr_q;
  logic [XLEN-1:0] q_inst [2];
  logic [XLEN-1:0] q_pc [2];
  logic            granted;
  logic            resp_valid;
  logic            q_empty;
  logic            q_push;
  logic            q_pop;

  // Queued words plus the one in flight stay below two
  assign imem.req   = active_q & ((count_q + {1'b0, pend_q}) < 2'd2);
  assign imem.we    = 1'b0;
  assign imem.addr  = pc_q;
  assign imem.wdata = '0;
  assign granted    = imem.req & imem.gnt;

  assign resp_valid = imem.rvalid & ~drop_q;
  assign q_empty    = (count_q == 2'd0);

  // Empty queue passes the returning word straight to decode
  assign inst_valid_o = ~q_empty | resp_valid;
  assign inst_o       = q_empty ? imem.rdata : q_inst[rd_ptr_q];
  assign inst_pc_o    = q_empty ? resp_pc_q : q_pc[rd_ptr_q];

  assign q_pop  = pop_i & ~q_empty;
  assign q_push = resp_valid & ~(pop_i & q_empty);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      pc_q     <= RESET_PC;
      pend_q   <= 1'b0;
      drop_q   <= 1'b0;
      count_q  <= 2'd0;
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      pend_q   <= granted;
      // A word requested now belongs to the old path
      drop_q   <= redirect_i.valid & granted;
      if (redirect_i.valid) begin
        pc_q     <= redirect_i.pc;
        count_q  <= 2'd0;
        rd_ptr_q <= 1'b0;
        wr_ptr_q <= 1'b0;
      end else begin
        if (granted) begin
          pc_q <= pc_q + XLEN'(4);
        end
        if (q_push) begin
          wr_ptr_q <= ~wr_ptr_q;
        end
        if (q_pop) begin
          rd_ptr_q <= ~rd_ptr_q;
        end
        count_q <= count_q + {1'b0, q_push} - {1'b0, q_pop};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (granted) begin
      resp_pc_q <= pc_q;
    end
    if (q_push && !redirect_i.valid) begin
      q_inst[wr_ptr_q] <= imem.rdata;
      q_pc[wr_ptr_q]   <= resp_pc_q;
    end
  end

  // Credit check at issue keeps room for every return
  a_queue_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    q_push |-> count_q != 2'd2
  ) else $error("instruction queue overflow");

endmodule

`default_nettype wire

/* core/decode.sv */
`timescale 1ns/1ns
`default_nettype none

module decode
  import cpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            inst_valid_i,
  input  logic [XLEN-1:0] inst_i,
  input  logic [XLEN-1:0] inst_pc_i,
  output logic            pop_o,
  output reg_addr_t       rs1_addr_o,
  output reg_addr_t       rs2_addr_o,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  rf_wr_t          fwd_i,
  input  redirect_t       redirect_i,
  input  logic            accept_i,
  output de_op_t          op_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  reg_addr_t       rd;
  logic [XLEN-1:0] imm_itype;
  logic [XLEN-1:0] imm_stype;
  logic [XLEN-1:0] imm_btype;
  logic [XLEN-1:0] imm_utype;
  logic [XLEN-1:0] imm_jtype;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic            load_en;
  logic            valid_q;
  de_op_t          dec;
  de_op_t          op_q;

  assign opcode     = inst_i[6:0];
  assign funct3     = inst_i[14:12];
  assign funct7     = inst_i[31:25];
  assign rd         = inst_i[11:7];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  assign imm_itype = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_stype = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_btype = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
  assign imm_utype = {inst_i[31:12], 12'b0};
  assign imm_jtype = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};

  // Result being written this cycle is not yet in the register file
  assign rs1_val = (fwd_i.we && fwd_i.rd != '0 && fwd_i.rd == rs1_addr_o) ?
                   fwd_i.data : rs1_data_i;
  assign rs2_val = (fwd_i.we && fwd_i.rd != '0 && fwd_i.rd == rs2_addr_o) ?
                   fwd_i.data : rs2_data_i;

  always_comb begin
    dec       = '0;
    dec.valid = 1'b1;
    dec.op    = OP_NOP;
    dec.pc    = inst_pc_i;
    dec.rs1   = rs1_val;
    dec.rs2   = rs2_val;
    case (opcode)
      OPC_OP: begin
        dec.rd = rd;
        if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) dec.op = OP_ADD;
        else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) dec.op = OP_SUB;
        else if (funct3 == F3_AND && funct7 == F7_BASE) dec.op = OP_AND;
        else if (funct3 == F3_OR && funct7 == F7_BASE) dec.op = OP_OR;
        else if (funct3 == F3_XOR && funct7 == F7_BASE) dec.op = OP_XOR;
        else dec.rd = '0;
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD_SUB) begin
          dec.op  = OP_ADDI;
          dec.rd  = rd;
          dec.imm = imm_itype;
        end
      end
      OPC_LUI: begin
        dec.op  = OP_LUI;
        dec.rd  = rd;
        dec.imm = imm_utype;
      end
      OPC_LOAD: begin
        if (funct3 == F3_LW) begin
          dec.op  = OP_LW;
          dec.rd  = rd;
          dec.imm = imm_itype;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_SW) begin
          dec.op  = OP_SW;
          dec.imm = imm_stype;
        end
      end
      OPC_BRANCH: begin
        dec.imm = imm_btype;
        if (funct3 == F3_BEQ) dec.op = OP_BEQ;
        else if (funct3 == F3_BNE) dec.op = OP_BNE;
      end
      OPC_JAL: begin
        dec.op  = OP_JAL;
        dec.rd  = rd;
        dec.imm = imm_jtype;
      end
      default: dec.op = OP_NOP;
    endcase
  end

  assign load_en = ~valid_q | accept_i;
  assign pop_o   = inst_valid_i & load_en & ~redirect_i.valid;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (redirect_i.valid) begin
      valid_q <= 1'b0;
    end else if (load_en) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      op_q <= dec;
    end
  end

  always_comb begin
    op_o       = op_q;
    op_o.valid = valid_q;
  end

endmodule

`default_nettype wire

/* core/execute.sv */
`timescale 1ns/1ns
`default_nettype none

module execute
  import cpu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  de_op_t       op_i,
  output logic         accept_o,
  mem_port_intf.master dmem,
  output rf_wr_t       rf_wr_o,
  output redirect_t    redirect_o
);

  logic            load_q;
  logic            is_lw;
  logic            is_sw;
  logic            lw_issue;
  logic            rs_equal;
  logic            writes_rd;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] link_pc;

  assign is_lw    = op_i.valid & (op_i.op == OP_LW);
  assign is_sw    = op_i.valid & (op_i.op == OP_SW);
  assign lw_issue = is_lw & ~load_q;

  // LW holds the stage until its data comes back
  assign accept_o = ~lw_issue;

  assign dmem.req   = lw_issue | is_sw;
  assign dmem.we    = is_sw;
  assign dmem.addr  = op_i.rs1 + op_i.imm;
  assign dmem.wdata = op_i.rs2;

  assign link_pc  = op_i.pc + XLEN'(4);
  assign rs_equal = (op_i.rs1 == op_i.rs2);

  always_comb begin
    writes_rd = 1'b1;
    case (op_i.op)
      OP_ADD:  result = op_i.rs1 + op_i.rs2;
      OP_SUB:  result = op_i.rs1 - op_i.rs2;
      OP_AND:  result = op_i.rs1 & op_i.rs2;
      OP_OR:   result = op_i.rs1 | op_i.rs2;
      OP_XOR:  result = op_i.rs1 ^ op_i.rs2;
      OP_ADDI: result = op_i.rs1 + op_i.imm;
      OP_LUI:  result = op_i.imm;
      OP_JAL:  result = link_pc;
      default: begin
        result    = '0;
        writes_rd = 1'b0;
      end
    endcase
  end

  assign redirect_o.valid = op_i.valid & ((op_i.op == OP_BEQ && rs_equal) ||
                                          (op_i.op == OP_BNE && !rs_equal) ||
                                          (op_i.op == OP_JAL));
  assign redirect_o.pc    = op_i.pc + op_i.imm;

  always_comb begin
    rf_wr_o.rd = op_i.rd;
    if (load_q) begin
      rf_wr_o.we   = dmem.rvalid & (op_i.rd != '0);
      rf_wr_o.data = dmem.rdata;
    end else begin
      rf_wr_o.we   = op_i.valid & writes_rd & (op_i.rd != '0);
      rf_wr_o.data = result;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      load_q <= 1'b0;
    end else begin
      load_q <= lw_issue;
    end
  end

  a_rvalid_in_load : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    dmem.rvalid |-> load_q
  ) else $error("data response outside load state");

endmodule

`default_nettype wire

/* core/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile
  import cpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  input  rf_wr_t          wr_i,
  input  reg_addr_t       raddr1_i,
  input  reg_addr_t       raddr2_i,
  output logic [XLEN-1:0] rdata1_o,
  output logic [XLEN-1:0] rdata2_o
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk) begin
    if (wr_i.we && wr_i.rd != '0) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

  // Execute masks x0 writes before they reach the port
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wr_i.we |-> wr_i.rd != '0
  ) else $error("write to x0 presented");

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
  import cpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  mem_port_intf.arbiter   imem,
  mem_port_intf.arbiter   dmem,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic [XLEN-1:0] mem_rdata_i
);

  logic rd_pend_q;
  logic rd_owner_d_q;

  // Data side always wins
  assign dmem.gnt = dmem.req;
  assign imem.gnt = imem.req & ~dmem.req;

  assign mem_req_o = dmem.req | imem.req;

  always_comb begin
    if (dmem.req) begin
      mem_we_o    = dmem.we;
      mem_addr_o  = dmem.addr;
      mem_wdata_o = dmem.wdata;
    end else begin
      mem_we_o    = imem.we;
      mem_addr_o  = imem.addr;
      mem_wdata_o = imem.wdata;
    end
  end

  // Remember who issued the read for the response cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_pend_q    <= 1'b0;
      rd_owner_d_q <= 1'b0;
    end else begin
      rd_pend_q    <= mem_req_o & ~mem_we_o;
      rd_owner_d_q <= dmem.req;
    end
  end

  assign dmem.rvalid = rd_pend_q & rd_owner_d_q;
  assign imem.rvalid = rd_pend_q & ~rd_owner_d_q;
  assign dmem.rdata  = mem_rdata_i;
  assign imem.rdata  = mem_rdata_i;

  a_one_grant : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(imem.gnt && dmem.gnt)
  ) else $error("both masters granted");

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top
  import cpu_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic [XLEN-1:0] mem_rdata_i
);

  // Fetch to decode
  logic            inst_valid;
  logic [XLEN-1:0] inst;
  logic [XLEN-1:0] inst_pc;
  logic            pop;

  // Register file reads
  reg_addr_t       rs1_addr;
  reg_addr_t       rs2_addr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  de_op_t          de_op;
  logic            accept;
  rf_wr_t          rf_wr;
  redirect_t       redirect;

  mem_port_intf imem_bus ();
  mem_port_intf dmem_bus ();

  ifetch #(
    .RESET_PC(RESET_PC)
  ) ifetch0 (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .imem        (imem_bus.master),
    .redirect_i  (redirect),
    .pop_i       (pop),
    .inst_valid_o(inst_valid),
    .inst_o      (inst),
    .inst_pc_o   (inst_pc)
  );

  decode decode0 (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .inst_valid_i(inst_valid),
    .inst_i      (inst),
    .inst_pc_i   (inst_pc),
    .pop_o       (pop),
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .fwd_i       (rf_wr),
    .redirect_i  (redirect),
    .accept_i    (accept),
    .op_o        (de_op)
  );

  execute execute0 (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .op_i      (de_op),
    .accept_o  (accept),
    .dmem      (dmem_bus.master),
    .rf_wr_o   (rf_wr),
    .redirect_o(redirect)
  );

  regfile regfile0 (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wr_i    (rf_wr),
    .raddr1_i(rs1_addr),
    .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data),
    .rdata2_o(rs2_data)
  );

  mem_arbiter mem_arbiter0 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .imem       (imem_bus.arbiter),
    .dmem       (dmem_bus.arbiter),
    .mem_req_o  (mem_req_o),
    .mem_we_o   (mem_we_o),
    .mem_addr_o (mem_addr_o),
    .mem_wdata_o(mem_wdata_o),
    .mem_rdata_i(mem_rdata_i)
  );

endmodule

`default_nettype wire

/* dv/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu
  import cpu_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 5;
  localparam int RESET_CYCLES    = 10;
  localparam int RUN_CYCLES      = 400;
  localparam int SETTLE_CYCLES   = 20;
  localparam int RANDOM_ROUNDS   = 5;
  localparam int PAIRS_PER_ROUND = 10;
  localparam int NUM_RUNS        = 5 + RANDOM_ROUNDS;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * (RESET_CYCLES + RUN_CYCLES + SETTLE_CYCLES + 1);

  // {funct7, funct3} of the register-register ops
  localparam logic [9:0] ADD_CODE = 10'b0000000_000;
  localparam logic [9:0] SUB_CODE = 10'b0100000_000;
  localparam logic [9:0] XOR_CODE = 10'b0000000_100;
  localparam logic [9:0] OR_CODE  = 10'b0000000_110;
  localparam logic [9:0] AND_CODE = 10'b0000000_111;
  localparam logic [2:0] BEQ_F3   = 3'b000;
  localparam logic [2:0] BNE_F3   = 3'b001;

  logic            clk;
  logic            rst_n;
  logic            mem_req;
  logic            mem_we;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic [XLEN-1:0] mem_rdata;

  logic [XLEN-1:0] mem [256];
  logic [7:0]      prog_idx;
  logic            rd_pend;
  logic [XLEN-1:0] rd_addr;
  logic [15:0]     lfsr_q;
  logic [XLEN-1:0] exp_addr [$];
  logic [XLEN-1:0] exp_data [$];
  logic [XLEN-1:0] obs_addr [$];
  logic [XLEN-1:0] obs_data [$];

  cpu_top UUT (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Strobe sampled mid-cycle, read data driven in the next cycle
  always begin
    @(negedge clk);
    rd_pend = 1'b0;
    if (mem_req === 1'b1) begin
      if (mem_we) begin
        mem[mem_addr[9:2]] = mem_wdata;
        obs_addr.push_back(mem_addr);
        obs_data.push_back(mem_wdata);
      end else begin
        rd_pend = 1'b1;
        rd_addr = mem_addr;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    mem_rdata = rd_pend ? mem[rd_addr[9:2]] : '0;
  end

  function automatic logic [31:0] reg_op(input logic [9:0] code, input reg_addr_t rd, rs1, rs2);
    return {code[9:3], rs2, rs1, code[2:0], rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_add(input reg_addr_t rd, rs1, input logic [XLEN-1:0] imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] upper_imm(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] load_word(input reg_addr_t rd, rs1, input logic [XLEN-1:0] imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input reg_addr_t rs2, rs1,
                                             input logic [XLEN-1:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                                         input logic [XLEN-1:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jump_link(input reg_addr_t rd, input logic [XLEN-1:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [XLEN-1:0] w);
    w = '0;
    for (int i = 0; i < XLEN; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[XLEN-2:0], lfsr_q[0]};
    end
  endtask

  task automatic fail_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic emit(input logic [31:0] w);
    mem[prog_idx] = w;
    prog_idx = prog_idx + 8'd1;
  endtask

  task automatic put_data(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] value);
    mem[addr[9:2]] = value;
  endtask

  task automatic store_and_expect(input reg_addr_t rs2, input logic [XLEN-1:0] addr,
                                  input logic [XLEN-1:0] value);
    emit(store_word(rs2, 5'd0, addr));
    exp_addr.push_back(addr);
    exp_data.push_back(value);
  endtask

  // ADDI sign-extends its low 12 bits, so LUI takes the rounded upper part
  task automatic load_const(input reg_addr_t rd, input logic [XLEN-1:0] value);
    logic [XLEN-1:0] rounded;
    rounded = value + 32'h800;
    emit(upper_imm(rd, rounded[31:12]));
    emit(imm_add(rd, rd, value));
  endtask

  task automatic check_store(input string name, input logic [XLEN-1:0] got_addr, got_data,
                             input logic [XLEN-1:0] want_addr, want_data);
    if (got_addr !== want_addr) begin
      $display("Mismatch at %0t ns: %s address got %h expected %h",
               $time, name, got_addr, want_addr);
      fail_run();
    end
    if (got_data !== want_data) begin
      $display("Mismatch at %0t ns: %s data got %h expected %h",
               $time, name, got_data, want_data);
      fail_run();
    end
  endtask

  task automatic start_test();
    @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b0;
    mem = '{default: '0};
    prog_idx = '0;
    exp_addr.delete();
    exp_data.delete();
    obs_addr.delete();
    obs_data.delete();
  endtask

  task automatic run_and_check(input string name);
    int cycles;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    cycles = 0;
    while (obs_addr.size() < exp_addr.size() && cycles < RUN_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (obs_addr.size() < exp_addr.size()) begin
      $display("Error at %0t ns: %s made only %0d of %0d stores within %0d cycles",
               $time, name, obs_addr.size(), exp_addr.size(), RUN_CYCLES);
      fail_run();
    end
    // Extra stores would show up while the final loop spins
    repeat (SETTLE_CYCLES) @(posedge clk);
    if (obs_addr.size() > exp_addr.size()) begin
      $display("Error at %0t ns: %s made %0d stores where %0d were expected",
               $time, name, obs_addr.size(), exp_addr.size());
      fail_run();
    end
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_store($sformatf("%s store %0d", name, i), obs_addr[i], obs_data[i],
                  exp_addr[i], exp_data[i]);
    end
  endtask

  task automatic alu_chain_test();
    logic [XLEN-1:0] v1, v2, v3, v4, v5, v6, v7, v8;
    start_test();
    v1 = 100;
    v2 = v1 - 7;
    v3 = v1 + v2;
    v4 = v3 - v1;
    v5 = 32'h12345000;
    v6 = v5 ^ v3;
    v7 = v6 | v2;
    v8 = v7 & v4;
    emit(imm_add(5'd1, 5'd0, 100));
    emit(imm_add(5'd2, 5'd1, -7));
    emit(reg_op(ADD_CODE, 5'd3, 5'd1, 5'd2));
    emit(reg_op(SUB_CODE, 5'd4, 5'd3, 5'd1));
    emit(upper_imm(5'd5, 20'h12345));
    emit(reg_op(XOR_CODE, 5'd6, 5'd5, 5'd3));
    emit(reg_op(OR_CODE, 5'd7, 5'd6, 5'd2));
    emit(reg_op(AND_CODE, 5'd8, 5'd7, 5'd4));
    store_and_expect(5'd8, 'h300, v8);
    store_and_expect(5'd7, 'h304, v7);
    store_and_expect(5'd6, 'h308, v6);
    store_and_expect(5'd5, 'h30C, v5);
    store_and_expect(5'd4, 'h310, v4);
    store_and_expect(5'd3, 'h314, v3);
    emit(jump_link(5'd0, '0));
    run_and_check("alu chain");
  endtask

  task automatic load_use_test();
    start_test();
    put_data('h380, 32'hCAFE_0123);
    put_data('h384, 32'h0BAD_F00D);
    emit(imm_add(5'd4, 5'd0, 77));
    emit(imm_add(5'd1, 5'd0, 'h380));
    emit(load_word(5'd2, 5'd1, 0));
    emit(reg_op(ADD_CODE, 5'd3, 5'd2, 5'd4));
    store_and_expect(5'd3, 'h300, 32'hCAFE_0123 + 32'd77);
    emit(load_word(5'd5, 5'd1, 4));
    store_and_expect(5'd5, 'h304, 32'h0BAD_F00D);
    emit(jump_link(5'd0, '0));
    run_and_check("load use");
  endtask

  // Taken branches skip two stores to addresses that must stay untouched
  task automatic branch_test();
    logic [XLEN-1:0] v1, v2, v3;
    start_test();
    v1 = 5;
    v2 = 5;
    v3 = 9;
    emit(imm_add(5'd1, 5'd0, v1));
    emit(imm_add(5'd2, 5'd0, v2));
    emit(imm_add(5'd3, 5'd0, v3));
    emit(branch(BEQ_F3, 5'd1, 5'd2, 12));
    emit(store_word(5'd1, 5'd0, 'h3F0));
    emit(store_word(5'd1, 5'd0, 'h3F4));
    store_and_expect(5'd1, 'h300, v1);
    emit(branch(BEQ_F3, 5'd1, 5'd3, 12));
    store_and_expect(5'd3, 'h304, v3);
    emit(branch(BNE_F3, 5'd1, 5'd3, 12));
    emit(store_word(5'd2, 5'd0, 'h3F8));
    emit(store_word(5'd2, 5'd0, 'h3FC));
    store_and_expect(5'd3, 'h308, v3);
    emit(branch(BNE_F3, 5'd1, 5'd2, 12));
    store_and_expect(5'd2, 'h30C, v2);
    emit(jump_link(5'd0, '0));
    run_and_check("branch");
  endtask

  task automatic jal_test();
    logic [7:0]      jal_idx;
    logic [XLEN-1:0] link;
    start_test();
    emit(imm_add(5'd1, 5'd0, 9));
    jal_idx = prog_idx;
    link = {{(XLEN-10){1'b0}}, jal_idx, 2'b00} + 32'd4;
    emit(jump_link(5'd5, 12));
    emit(store_word(5'd1, 5'd0, 'h3F0));
    emit(store_word(5'd1, 5'd0, 'h3F4));
    store_and_expect(5'd5, 'h300, link);
    store_and_expect(5'd1, 'h304, 9);
    emit(jump_link(5'd0, '0));
    run_and_check("jal");
  endtask

  task automatic zero_reg_test();
    start_test();
    emit(imm_add(5'd1, 5'd0, 55));
    emit(imm_add(5'd0, 5'd0, 123));
    store_and_expect(5'd0, 'h300, '0);
    emit(reg_op(ADD_CODE, 5'd0, 5'd1, 5'd1));
    store_and_expect(5'd0, 'h304, '0);
    emit(upper_imm(5'd0, 20'hABCDE));
    emit(reg_op(ADD_CODE, 5'd2, 5'd0, 5'd1));
    store_and_expect(5'd2, 'h308, 55);
    emit(jump_link(5'd0, '0));
    run_and_check("x0");
  endtask

  // Pairs are split over rounds so each program fits below the data area
  task automatic random_alu_test();
    logic [XLEN-1:0] a, b;
    logic [XLEN-1:0] base;
    for (int round = 0; round < RANDOM_ROUNDS; round++) begin
      start_test();
      for (int p = 0; p < PAIRS_PER_ROUND; p++) begin
        random_word(a);
        random_word(b);
        base = 32'h300 + 32'(12 * p);
        load_const(5'd10, a);
        load_const(5'd11, b);
        emit(reg_op(ADD_CODE, 5'd12, 5'd10, 5'd11));
        emit(reg_op(SUB_CODE, 5'd13, 5'd10, 5'd11));
        emit(reg_op(XOR_CODE, 5'd14, 5'd10, 5'd11));
        store_and_expect(5'd12, base, a + b);
        store_and_expect(5'd13, base + 32'd4, a - b);
        store_and_expect(5'd14, base + 32'd8, a ^ b);
      end
      emit(jump_link(5'd0, '0));
      run_and_check($sformatf("random round %0d", round));
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error at %0t ns: watchdog expired before the last test ended", $time);
    fail_run();
  end

  initial begin
    rst_n     = 1'b0;
    mem_rdata = '0;
    lfsr_q    = 16'd7857;
    prog_idx  = '0;
    alu_chain_test();
    load_use_test();
    branch_test();
    jal_test();
    zero_reg_test();
    random_alu_test();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
common/cpu_pkg.sv
common/mem_port_intf.sv
core/ifetch.sv
core/decode.sv
core/execute.sv
core/regfile.sv
verilog/mem_arbiter.sv
verilog/cpu_top.sv
dv/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_cpu -Mdir obj_dir -o sim_cpu

# The simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "All tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation finished cleanly"
